// File: source/mcu_pkg.sv
package mcu_pkg;

   localparam int CODE_AW    = 9;
   localparam int DATA_AW    = 9;     // msb stays zero, 256 bytes used
   localparam int LOAD_BYTES = 64;
   localparam int BIT_CYCLES = 104;   // clocks per serial bit
   localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);

   localparam logic [15:0] TX_PORT_ADDR = 16'h0201;

   typedef enum logic [2:0] {
      ST_FETCH   = 3'd0,
      ST_DECODE0 = 3'd1,
      ST_DECODE1 = 3'd2,
      ST_DECODE2 = 3'd3,
      ST_EXECUTE = 3'd4
   } cpu_state_e;

   // register forms (rn) hold the base value, low three bits zero
   typedef enum logic [7:0] {
      NOP    = 8'h00,   // also stands in for unsupported bytes
      LJMP   = 8'h02,
      INCA   = 8'h04,
      INCR   = 8'h08,
      DECA   = 8'h14,
      DECR   = 8'h18,
      ADDAI  = 8'h24,
      ADDAR  = 8'h28,
      JC     = 8'h40,
      JNC    = 8'h50,
      JZ     = 8'h60,
      XRLA   = 8'h64,
      MOVAI  = 8'h74,
      MOVRI  = 8'h78,
      SJMP   = 8'h80,
      MOVDP  = 8'h90,
      SUBBAI = 8'h94,
      CLRC   = 8'hC3,
      SETBC  = 8'hD3,
      CLRA   = 8'hE4,
      MOVAD  = 8'hE5,
      MOVAR  = 8'hE8,
      MOVXDA = 8'hF0,
      CPLA   = 8'hF4,
      MOVDA  = 8'hF5,
      MOVRA  = 8'hF8
   } opcode_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_RECV,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_SEND
   } tx_state_e;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   output logic [7:0] o_rx_data,
   output logic       o_rx_valid
);
   import mcu_pkg::*;

   rx_state_e            state;
   logic                 rx_q;       // resampled line
   logic [BIT_CNT_W-1:0] cnt;
   logic                 half_bit;
   logic                 full_bit;
   logic [7:0]           shreg;

   assign half_bit = (cnt == BIT_CNT_W'(BIT_CYCLES / 2 - 1));
   assign full_bit = (cnt == BIT_CNT_W'(BIT_CYCLES - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_q <= 1'b1;
      else         rx_q <= i_uart_rx;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_q) state <= RX_START;   // falling edge
            end
            RX_START: begin
               if (half_bit) begin
                  cnt   <= '0;
                  state <= rx_q ? RX_IDLE : RX_RECV;   // high again means a glitch
               end
            end
            RX_RECV: begin
               if (full_bit) begin
                  cnt <= '0;
                  if (shreg[0]) state <= RX_STOP;   // sentinel hit bit 0, eighth bit in
               end
            end
            RX_STOP: begin
               if (full_bit) begin
                  cnt   <= '0;
                  state <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // lsb first, marker bit walks down ahead of the data
   always_ff @(posedge i_clk) begin
      if (state == RX_START && half_bit)     shreg <= 8'h80;
      else if (state == RX_RECV && full_bit) shreg <= {rx_q, shreg[7:1]};
   end

   assign o_rx_data  = shreg;
   assign o_rx_valid = (state == RX_STOP) && full_bit;

   a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_rx_valid |=> !o_rx_valid);

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_tx_valid,
   input  logic [7:0] i_tx_data,
   output logic       o_tx_ready,
   output logic       o_uart_tx
);
   import mcu_pkg::*;

   tx_state_e            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic [3:0]           bit_cnt;
   logic [7:0]           shreg;
   logic                 full_bit;

   assign full_bit   = (cnt == BIT_CNT_W'(BIT_CYCLES - 1));
   assign o_tx_ready = (state == TX_IDLE);
   assign o_uart_tx  = (state == TX_IDLE)  ? 1'b1 :
                       (state == TX_START) ? 1'b0 :
                                             shreg[7];   // msb first

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= full_bit ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt <= '0;
               if (i_tx_valid) state <= TX_START;
            end
            TX_START: begin
               if (full_bit) begin
                  state   <= TX_SEND;
                  bit_cnt <= '0;
               end
            end
            TX_SEND: begin
               if (full_bit) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd8) state <= TX_IDLE;   // 8 data + stop
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // ones shift in behind the data and form the stop bit
   always_ff @(posedge i_clk) begin
      if (i_tx_valid && o_tx_ready)          shreg <= i_tx_data;
      else if (state == TX_SEND && full_bit) shreg <= {shreg[6:0], 1'b1};
   end

endmodule

// File: source/program_loader.sv
`timescale 1ns/1ps

module program_loader (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic [7:0]                  i_rx_data,
   input  logic                        i_rx_valid,
   input  logic [mcu_pkg::CODE_AW-1:0] i_pc,
   output logic                        o_load_done,
   output logic                        o_code_wr,
   output logic [mcu_pkg::CODE_AW-1:0] o_code_addr,
   output logic [7:0]                  o_code_data
);
   import mcu_pkg::*;

   logic [CODE_AW-1:0] cnt;     // bytes written so far
   logic               done;

   assign o_code_wr   = i_rx_valid & ~done;
   assign o_code_addr = done ? i_pc : cnt;
   assign o_code_data = i_rx_data;
   assign o_load_done = done;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         cnt  <= '0;
         done <= 1'b0;
      end else if (o_code_wr) begin
         cnt <= cnt + 1'b1;
         if (cnt == CODE_AW'(LOAD_BYTES - 1)) done <= 1'b1;   // sticky until reset
      end
   end

endmodule

// File: source/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_load_done,
   input  logic [7:0]                  i_code_data,
   input  logic                        i_acc_zero,
   input  logic                        i_carry,
   input  logic                        i_exec_stall,
   output logic [mcu_pkg::CODE_AW-1:0] o_pc,
   output mcu_pkg::opcode_e            o_opcode,
   output logic [2:0]                  o_reg_idx,
   output logic [7:0]                  o_imm1,
   output logic [7:0]                  o_imm2,
   output logic                        o_exec
);
   import mcu_pkg::*;

   cpu_state_e         state;
   cpu_state_e         state_nxt;
   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] pc_nxt;
   opcode_e            dec_op;
   logic [1:0]         dec_len;
   logic [1:0]         cur_len;
   logic               take_rel;
   logic [CODE_AW-1:0] rel_off;
   logic [15:0]        abs_addr;

   // rn forms fold to their base, anything unknown becomes a 1 byte nop
   function automatic opcode_e normalize(input logic [7:0] b);
      logic [7:0] base;
      base = {b[7:3], 3'b000};
      case (base)
         INCR, DECR, ADDAR, MOVRI, MOVAR, MOVRA: normalize = opcode_e'(base);
         default: begin
            case (b)
               LJMP, INCA, DECA, ADDAI, JC, JNC, JZ, XRLA, MOVAI, SJMP,
               MOVDP, SUBBAI, CLRC, SETBC, CLRA, MOVAD, MOVXDA, CPLA,
               MOVDA:   normalize = opcode_e'(b);
               default: normalize = NOP;
            endcase
         end
      endcase
   endfunction

   function automatic logic [1:0] op_len(input opcode_e op);
      case (op)
         LJMP, MOVDP: op_len = 2'd3;
         ADDAI, SUBBAI, XRLA, MOVAI, MOVRI, MOVAD, MOVDA,
         SJMP, JZ, JC, JNC: op_len = 2'd2;
         default:     op_len = 2'd1;
      endcase
   endfunction

   assign dec_op   = normalize(i_code_data);
   assign dec_len  = op_len(dec_op);
   assign cur_len  = op_len(o_opcode);
   assign rel_off  = {{(CODE_AW - 8){o_imm1[7]}}, o_imm1};
   assign abs_addr = {o_imm1, o_imm2};
   assign take_rel = (o_opcode == SJMP) | ((o_opcode == JZ) & i_acc_zero) |
                     ((o_opcode == JC) & i_carry) | ((o_opcode == JNC) & ~i_carry);

   //////////////////////////////////////////////////////////////////////
   // sequencer and pc
   // pc runs one byte ahead of the code data, so in execute it already
   // points at the next instruction

   always_comb begin
      state_nxt = state;
      pc_nxt    = pc;
      case (state)
         ST_FETCH: begin
            if (i_load_done) begin
               state_nxt = ST_DECODE0;
               pc_nxt    = pc + 1'b1;
            end
         end
         ST_DECODE0: begin
            if (dec_len == 2'd1) begin
               state_nxt = ST_EXECUTE;
            end else begin
               state_nxt = ST_DECODE1;
               pc_nxt    = pc + 1'b1;
            end
         end
         ST_DECODE1: begin
            if (cur_len == 2'd3) begin
               state_nxt = ST_DECODE2;
               pc_nxt    = pc + 1'b1;
            end else begin
               state_nxt = ST_EXECUTE;
            end
         end
         ST_DECODE2: state_nxt = ST_EXECUTE;
         ST_EXECUTE: begin
            if (!i_exec_stall) state_nxt = ST_FETCH;   // held while tx is busy
            if (take_rel)              pc_nxt = pc + rel_off;
            else if (o_opcode == LJMP) pc_nxt = abs_addr[CODE_AW-1:0];
         end
         default: state_nxt = ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state     <= ST_FETCH;
         pc        <= '0;
         o_opcode  <= NOP;
         o_reg_idx <= '0;
      end else begin
         state <= state_nxt;
         pc    <= pc_nxt;
         if (state == ST_DECODE0) begin
            o_opcode  <= dec_op;
            o_reg_idx <= i_code_data[2:0];
         end
      end
   end

   // operand bytes
   always_ff @(posedge i_clk) begin
      if (state == ST_DECODE1) o_imm1 <= i_code_data;
      if (state == ST_DECODE2) o_imm2 <= i_code_data;
   end

   assign o_pc   = pc;
   assign o_exec = (state == ST_EXECUTE);

   a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
      state inside {ST_FETCH, ST_DECODE0, ST_DECODE1, ST_DECODE2, ST_EXECUTE});

endmodule

// File: source/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  mcu_pkg::opcode_e            i_opcode,
   input  logic [2:0]                  i_reg_idx,
   input  logic [7:0]                  i_imm1,
   input  logic [7:0]                  i_imm2,
   input  logic                        i_exec,
   input  logic [7:0]                  i_data_data,
   input  logic                        i_tx_ready,
   output logic                        o_acc_zero,
   output logic                        o_carry,
   output logic                        o_exec_stall,
   output logic                        o_data_wr,
   output logic [mcu_pkg::DATA_AW-1:0] o_data_addr,
   output logic [7:0]                  o_data_data,
   output logic                        o_tx_valid,
   output logic [7:0]                  o_tx_data
);
   import mcu_pkg::*;

   logic [7:0]  acc;
   logic [7:0]  acc_nxt;
   logic [7:0]  regs [8];
   logic [7:0]  r_sel;
   logic [7:0]  r_nxt;
   logic        r_wr;
   logic        carry;
   logic        carry_nxt;
   logic [15:0] dptr;
   logic [7:0]  alu_b;
   logic        alu_sub;
   logic [8:0]  alu_res;
   logic        upd;

   assign upd   = i_exec & ~o_exec_stall;   // commit on the last execute cycle
   assign r_sel = regs[i_reg_idx];

   //////////////////////////////////////////////////////////////////////
   // alu

   always_comb begin
      alu_b   = i_imm1;
      alu_sub = 1'b0;
      case (i_opcode)
         ADDAR:  alu_b = r_sel;
         INCA:   alu_b = 8'd1;
         DECA: begin
            alu_b   = 8'd1;
            alu_sub = 1'b1;
         end
         SUBBAI: alu_sub = 1'b1;
         default: ;
      endcase
   end

   // bit 8 is carry out on add, borrow on subtract
   assign alu_res = alu_sub ?
                    ({1'b0, acc} - {1'b0, alu_b} - {8'd0, carry & (i_opcode == SUBBAI)}) :
                    ({1'b0, acc} + {1'b0, alu_b});

   always_comb begin
      acc_nxt   = acc;
      carry_nxt = carry;
      r_nxt     = r_sel;
      r_wr      = 1'b0;
      case (i_opcode)
         MOVAI: acc_nxt = i_imm1;
         ADDAI, ADDAR, SUBBAI: begin
            acc_nxt   = alu_res[7:0];
            carry_nxt = alu_res[8];
         end
         INCA, DECA: acc_nxt = alu_res[7:0];   // carry untouched
         XRLA:  acc_nxt = acc ^ i_imm1;
         CLRA:  acc_nxt = 8'd0;
         CPLA:  acc_nxt = ~acc;
         MOVAR: acc_nxt = r_sel;
         MOVAD: acc_nxt = i_data_data;
         CLRC:  carry_nxt = 1'b0;
         SETBC: carry_nxt = 1'b1;
         MOVRA: begin
            r_nxt = acc;
            r_wr  = 1'b1;
         end
         MOVRI: begin
            r_nxt = i_imm1;
            r_wr  = 1'b1;
         end
         INCR: begin
            r_nxt = r_sel + 8'd1;
            r_wr  = 1'b1;
         end
         DECR: begin
            r_nxt = r_sel - 8'd1;
            r_wr  = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         for (int i = 0; i < 8; i++) regs[i] <= '0;
      end else if (upd) begin
         acc   <= acc_nxt;
         carry <= carry_nxt;
         if (r_wr) regs[i_reg_idx] <= r_nxt;
         if (i_opcode == MOVDP) dptr <= {i_imm1, i_imm2};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data memory and transmit port

   assign o_acc_zero   = (acc == 8'd0);
   assign o_carry      = carry;
   assign o_data_wr    = i_exec & (i_opcode == MOVDA);
   assign o_data_addr  = {{(DATA_AW - 8){1'b0}}, i_imm1};   // movad reads the same address
   assign o_data_data  = acc;
   assign o_tx_valid   = i_exec & (i_opcode == MOVXDA) & (dptr == TX_PORT_ADDR);
   assign o_tx_data    = acc;
   assign o_exec_stall = o_tx_valid & ~i_tx_ready;

   // byte offered to the transmitter waits unchanged until taken
   a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)));

endmodule

// File: source/mcu_top.sv
`timescale 1ns/1ps

module mcu_top (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_uart_rx,
   input  logic [7:0]                  i_code_data,
   input  logic [7:0]                  i_data_data,
   output logic                        o_uart_tx,
   output logic                        o_code_wr,
   output logic [mcu_pkg::CODE_AW-1:0] o_code_addr,
   output logic [7:0]                  o_code_data,
   output logic                        o_data_wr,
   output logic [mcu_pkg::DATA_AW-1:0] o_data_addr,
   output logic [7:0]                  o_data_data
);
   import mcu_pkg::*;

   logic [7:0]         rx_data;
   logic               rx_valid;
   logic               load_done;
   logic [CODE_AW-1:0] pc;
   opcode_e            opcode;
   logic [2:0]         reg_idx;
   logic [7:0]         imm1;
   logic [7:0]         imm2;
   logic               exec;
   logic               acc_zero;
   logic               carry;
   logic               exec_stall;
   logic               tx_valid;
   logic               tx_ready;
   logic [7:0]         tx_data;

   uart_rx uart_rx_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_uart_rx  (i_uart_rx),
      .o_rx_data  (rx_data),
      .o_rx_valid (rx_valid)
   );

   program_loader program_loader_inst (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx_data   (rx_data),
      .i_rx_valid  (rx_valid),
      .i_pc        (pc),
      .o_load_done (load_done),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data)
   );

   cpu_control cpu_control_inst (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_load_done  (load_done),
      .i_code_data  (i_code_data),
      .i_acc_zero   (acc_zero),
      .i_carry      (carry),
      .i_exec_stall (exec_stall),
      .o_pc         (pc),
      .o_opcode     (opcode),
      .o_reg_idx    (reg_idx),
      .o_imm1       (imm1),
      .o_imm2       (imm2),
      .o_exec       (exec)
   );

   cpu_datapath cpu_datapath_inst (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_opcode     (opcode),
      .i_reg_idx    (reg_idx),
      .i_imm1       (imm1),
      .i_imm2       (imm2),
      .i_exec       (exec),
      .i_data_data  (i_data_data),
      .i_tx_ready   (tx_ready),
      .o_acc_zero   (acc_zero),
      .o_carry      (carry),
      .o_exec_stall (exec_stall),
      .o_data_wr    (o_data_wr),
      .o_data_addr  (o_data_addr),
      .o_data_data  (o_data_data),
      .o_tx_valid   (tx_valid),
      .o_tx_data    (tx_data)
   );

   uart_tx uart_tx_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_valid (tx_valid),
      .i_tx_data  (tx_data),
      .o_tx_ready (tx_ready),
      .o_uart_tx  (o_uart_tx)
   );

endmodule

// File: sim/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

logic [15:0] lfsr = 16'd3;
logic [7:0]  m_dmem [256];
logic [7:0]  exp_tx [$];
logic [8:0]  exp_wr_addr [$];
logic [7:0]  exp_wr_data [$];

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
   return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic rand_byte(output logic [7:0] b);
   b = '0;
   for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};
   end
endtask

//////////////////////////////////////////////////////////////////////
// reference interpreter, runs the image until the sjmp to itself

task automatic run_model();
   logic [7:0]  acc;
   logic [7:0]  r [8];
   logic        c;
   logic [15:0] dptr;
   logic [8:0]  pc;
   logic [8:0]  nxt;
   logic [8:0]  sum;
   logic [7:0]  b;
   logic [7:0]  op;
   logic [7:0]  i1;
   logic [7:0]  i2;
   logic [2:0]  rn;
   logic        halted;
   int          steps;
   acc    = '0;
   c      = 1'b0;
   dptr   = '0;
   pc     = '0;
   halted = 1'b0;
   steps  = 0;
   for (int i = 0; i < 8; i++) r[i] = '0;
   while (!halted) begin
      if (steps == 400) stop_with_error("model never reached the final loop");
      b  = image[pc];
      i1 = image[pc + 9'd1];
      i2 = image[pc + 9'd2];
      rn = b[2:0];
      op = ({b[7:3], 3'b000} inside {INCR, DECR, ADDAR, MOVRI, MOVAR, MOVRA}) ?
           {b[7:3], 3'b000} : b;
      case (op)
         LJMP, MOVDP: nxt = pc + 9'd3;
         ADDAI, SUBBAI, XRLA, MOVAI, MOVRI, MOVAD, MOVDA,
         SJMP, JZ, JC, JNC: nxt = pc + 9'd2;
         default:     nxt = pc + 9'd1;   // unknown bytes are 1 byte nops
      endcase
      if (op == SJMP && i1 == 8'hFE) begin
         halted = 1'b1;
      end else begin
         case (op)
            MOVAI:  acc = i1;
            ADDAI: begin
               sum = {1'b0, acc} + {1'b0, i1};
               {c, acc} = sum;
            end
            ADDAR: begin
               sum = {1'b0, acc} + {1'b0, r[rn]};
               {c, acc} = sum;
            end
            SUBBAI: begin
               sum = {1'b0, acc} - {1'b0, i1} - {8'd0, c};   // bit 8 is the borrow
               {c, acc} = sum;
            end
            XRLA:   acc = acc ^ i1;
            INCA:   acc = acc + 8'd1;
            DECA:   acc = acc - 8'd1;
            CLRA:   acc = '0;
            CPLA:   acc = ~acc;
            MOVAR:  acc = r[rn];
            MOVRA:  r[rn] = acc;
            MOVRI:  r[rn] = i1;
            INCR:   r[rn] = r[rn] + 8'd1;
            DECR:   r[rn] = r[rn] - 8'd1;
            MOVAD:  acc = m_dmem[i1];
            MOVDA: begin
               m_dmem[i1] = acc;
               exp_wr_addr.push_back({1'b0, i1});
               exp_wr_data.push_back(acc);
            end
            CLRC:   c = 1'b0;
            SETBC:  c = 1'b1;
            MOVDP:  dptr = {i1, i2};
            MOVXDA: if (dptr == TX_PORT_ADDR) exp_tx.push_back(acc);
            LJMP:   nxt = {i1[0], i2};
            SJMP:   nxt = nxt + {i1[7], i1};
            JZ:     if (acc == 8'd0) nxt = nxt + {i1[7], i1};
            JC:     if (c) nxt = nxt + {i1[7], i1};
            JNC:    if (!c) nxt = nxt + {i1[7], i1};
            default: ;
         endcase
         pc = nxt;
      end
      steps++;
   end
endtask

//////////////////////////////////////////////////////////////////////
// serial line helpers

// 8N1, lsb first
task automatic send_byte(input logic [7:0] b);
   i_uart_rx <= 1'b0;
   repeat (BIT_CYCLES) @(posedge i_clk);
   for (int i = 0; i < 8; i++) begin
      i_uart_rx <= b[i];
      repeat (BIT_CYCLES) @(posedge i_clk);
   end
   i_uart_rx <= 1'b1;
   repeat (BIT_CYCLES) @(posedge i_clk);
endtask

// transmitter sends msb first
task automatic receive_tx(output logic [7:0] b);
   b = '0;
   @(negedge o_uart_tx);
   repeat (BIT_CYCLES / 2) @(negedge i_clk);   // middle of the start bit
   check("o_uart_tx start bit", o_uart_tx, 0);
   for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge i_clk);
      b = {b[6:0], o_uart_tx};
   end
   repeat (BIT_CYCLES) @(negedge i_clk);
   check("o_uart_tx stop bit", o_uart_tx, 1);
endtask

`endif

// File: sim/tb_mcu.sv
`timescale 1ns/1ps

module tb_mcu;
   import mcu_pkg::*;

   logic               i_clk;
   logic               i_nrst;
   logic               i_uart_rx;
   logic [7:0]         i_code_data;
   logic [7:0]         i_data_data;
   logic               o_uart_tx;
   logic               o_code_wr;
   logic [CODE_AW-1:0] o_code_addr;
   logic [7:0]         o_code_data;
   logic               o_data_wr;
   logic [DATA_AW-1:0] o_data_addr;
   logic [7:0]         o_data_data;

   logic [7:0] cmem [512];
   logic [7:0] dmem [256];
   logic [7:0] image [512];   // program image, first LOAD_BYTES are sent
   int         img_len;
   int         code_wr_n = 0;
   int         data_wr_n = 0;
   int         tx_n = 0;
   logic       model_done = 1'b0;

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         stop_with_error($sformatf("ERROR at %0t: %s is %0h, expected %0h",
                                   $time, name, got, exp));
   endtask

   `include "tb_isa_model.svh"

   task automatic emit(input int n, input logic [7:0] b0, input logic [7:0] b1,
                       input logic [7:0] b2);
      image[img_len] = b0;
      if (n > 1) image[img_len + 1] = b1;
      if (n > 2) image[img_len + 2] = b2;
      img_len = img_len + n;
   endtask

   //////////////////////////////////////////////////////////////////////
   // program template, immediates and data addresses from the lfsr

   task automatic build_image();
      logic [7:0] v;
      int         tgt;
      img_len = 0;
      for (int a = 0; a < 512; a++) image[a] = 8'h00;
      emit(1, MOVXDA, 0, 0);   // dptr still 0, nothing sent
      emit(3, MOVDP, TX_PORT_ADDR[15:8], TX_PORT_ADDR[7:0]);
      rand_byte(v);
      emit(2, MOVAI, v, 0);
      rand_byte(v);
      emit(2, ADDAI, v, 0);
      rand_byte(v);
      emit(2, SUBBAI, v, 0);
      rand_byte(v);
      emit(2, 8'(MOVRI) + 8'd3, v, 0);
      rand_byte(v);
      emit(2, XRLA, v, 0);
      emit(1, 8'(ADDAR) + 8'd3, 0, 0);
      emit(1, 8'(MOVRA) + 8'd5, 0, 0);
      emit(1, 8'(INCR) + 8'd5, 0, 0);
      emit(1, 8'(DECR) + 8'd3, 0, 0);
      emit(1, 8'(MOVAR) + 8'd5, 0, 0);
      emit(1, INCA, 0, 0);
      emit(1, DECA, 0, 0);
      emit(1, CPLA, 0, 0);
      rand_byte(v);
      emit(2, MOVDA, v, 0);
      rand_byte(v);
      emit(2, MOVAD, v, 0);
      emit(1, MOVXDA, 0, 0);
      emit(1, 8'(MOVAR) + 8'd3, 0, 0);
      emit(1, MOVXDA, 0, 0);
      // branch section, each taken jump skips one acc change
      emit(1, CLRC, 0, 0);
      emit(2, JC, 8'h01, 0);    // not taken
      emit(1, INCA, 0, 0);
      emit(2, JNC, 8'h01, 0);   // taken
      emit(1, CPLA, 0, 0);
      emit(1, SETBC, 0, 0);
      emit(2, JNC, 8'h01, 0);
      emit(1, INCA, 0, 0);
      emit(2, JC, 8'h01, 0);
      emit(1, CPLA, 0, 0);
      emit(1, MOVXDA, 0, 0);
      emit(1, CLRA, 0, 0);
      emit(2, JZ, 8'h01, 0);    // taken
      emit(1, INCA, 0, 0);
      emit(1, CPLA, 0, 0);
      emit(2, JZ, 8'h01, 0);    // not taken
      emit(1, MOVXDA, 0, 0);
      emit(2, SJMP, 8'h01, 0);
      emit(1, INCA, 0, 0);
      tgt = img_len + 4;
      emit(3, LJMP, 8'(tgt >> 8), 8'(tgt));
      emit(1, INCA, 0, 0);
      // back to back sends, faster than the line
      emit(1, MOVXDA, 0, 0);
      emit(1, MOVXDA, 0, 0);
      emit(1, MOVXDA, 0, 0);
      emit(2, SJMP, 8'hFE, 0);
      while (img_len < LOAD_BYTES) emit(1, NOP, 0, 0);
   endtask

   mcu_top mcu_top_inst (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .i_code_data (i_code_data),
      .i_data_data (i_data_data),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .o_data_wr   (o_data_wr),
      .o_data_addr (o_data_addr),
      .o_data_data (o_data_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // memory models
   always @(posedge i_clk) begin
      if (o_code_wr) cmem[o_code_addr] <= o_code_data;
      i_code_data <= cmem[o_code_addr];   // synchronous read
   end

   assign i_data_data = dmem[o_data_addr[7:0]];

   always @(posedge i_clk) begin
      if (o_data_wr) dmem[o_data_addr[7:0]] <= o_data_data;
   end

   //////////////////////////////////////////////////////////////////////
   // monitors

   always @(posedge i_clk) begin
      if (i_nrst && o_code_wr) begin
         if (code_wr_n >= LOAD_BYTES) stop_with_error("code write after loading finished");
         check("o_code_addr", o_code_addr, code_wr_n);
         check("o_code_data", o_code_data, image[code_wr_n]);
         code_wr_n++;
      end
   end

   always @(posedge i_clk) begin
      if (i_nrst && o_data_wr) begin
         if (data_wr_n >= exp_wr_addr.size()) stop_with_error("unexpected data memory write");
         check("o_data_addr", o_data_addr, exp_wr_addr[data_wr_n]);
         check("o_data_data", o_data_data, exp_wr_data[data_wr_n]);
         data_wr_n++;
      end
   end

   initial begin
      logic [7:0] b;
      wait (i_nrst === 1'b1);
      forever begin
         receive_tx(b);
         if (tx_n >= exp_tx.size()) stop_with_error("unexpected extra byte on o_uart_tx");
         check("o_uart_tx byte", b, exp_tx[tx_n]);
         tx_n++;
      end
   end

   // watchdog, load time plus one frame per expected byte plus margin
   initial begin
      int limit;
      wait (model_done === 1'b1);
      limit = 4 + (LOAD_BYTES * 10 + exp_tx.size() * 10 + 40) * BIT_CYCLES + 2000;
      repeat (limit) @(posedge i_clk);
      stop_with_error("timeout, the program did not finish sending its bytes");
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      logic [7:0] b;
      i_nrst      = 1'b0;
      i_uart_rx   = 1'b1;
      i_code_data = 8'h00;
      for (int a = 0; a < 512; a++) cmem[a] = 8'(a ^ (a >> 3));
      for (int a = 0; a < 256; a++) begin
         rand_byte(b);
         dmem[a]   = b;
         m_dmem[a] = b;
      end
      build_image();
      run_model();
      model_done = 1'b1;
      repeat (4) @(posedge i_clk);
      i_nrst <= 1'b1;
      @(negedge i_clk);
      check("o_uart_tx", o_uart_tx, 1);
      check("o_code_wr", o_code_wr, 0);
      check("o_data_wr", o_data_wr, 0);
      @(posedge i_clk);
      for (int i = 0; i < LOAD_BYTES; i++) send_byte(image[i]);
      wait (tx_n == exp_tx.size() && data_wr_n == exp_wr_addr.size());
      repeat (12 * BIT_CYCLES) @(posedge i_clk);   // room for stray traffic
      check("code write count", code_wr_n, LOAD_BYTES);
      $display("Done: no errors");
      $finish;
   end

endmodule

// File: tb.f
+incdir+sim
source/mcu_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/program_loader.sv
source/cpu_control.sv
source/cpu_datapath.sv
source/mcu_top.sv
sim/tb_mcu.sv
